//--- fp16_add_pkg.sv
// fp16 adder shared types
package fp16_add_pkg;

    // half precision field widths
    localparam int EXP_W = 5;
    localparam int FRAC_W = 10;

    // hidden bit, fraction and two guard bits
    localparam int MAN_W = 13;

    // all-ones exponent, used here only as the infinity code
    localparam int EXP_INF = 31;

    // one ieee half precision value, msb first
    typedef struct packed {
        logic              sign;
        logic [EXP_W-1:0]  exp;
        logic [FRAC_W-1:0] frac;
    } fp16_t;

    // operation select
    // subtract is handled by flipping the sign of b up front
    typedef enum logic {
        OP_ADD = 1'b0,
        OP_SUB = 1'b1
    } fp_op_e;

    // one request into the pipe
    typedef struct packed {
        fp16_t  a;
        fp16_t  b;
        fp_op_e op;
    } add_req_t;

    // align stage output
    // the shifted operand is the one with the smaller exponent
    typedef struct packed {
        logic             sign_shifted;
        logic [MAN_W-1:0] frac_shifted;
        logic             sign_not_shifted;
        logic [MAN_W-1:0] frac_not_shifted;
        logic [EXP_W-1:0] exp_max;
    } aligned_t;

    // sum stage output
    // mag carries one extra bit above the hidden bit for add carry out
    typedef struct packed {
        logic             sign;
        logic [MAN_W:0]   mag;
        logic [EXP_W-1:0] exp;
    } sum_t;

endpackage

//--- add_align.sv
// fp16 add align stage
`timescale 1ns/1ns

module add_align (
    input  fp16_add_pkg::add_req_t req,
    output fp16_add_pkg::aligned_t aligned
);

    // operands after the opcode has been applied
    fp16_add_pkg::fp16_t a_op;
    fp16_add_pkg::fp16_t b_op;

    // guarded significands, zero when the exponent is zero
    logic [fp16_add_pkg::MAN_W-1:0] sig_a;
    logic [fp16_add_pkg::MAN_W-1:0] sig_b;

    // exponent compare result and unsigned difference
    logic                           a_ge_b;
    logic [fp16_add_pkg::EXP_W-1:0] exp_diff;

    always_comb begin
        a_op = req.a;
        b_op = req.b;

        // a - b is a + (-b)
        if (req.op == fp16_add_pkg::OP_SUB) begin
            b_op.sign = ~req.b.sign;
        end

        // exponent zero flushes to zero since subnormals are not supported
        sig_a = (a_op.exp == '0) ? '0 : {1'b1, a_op.frac, 2'b00};
        sig_b = (b_op.exp == '0) ? '0 : {1'b1, b_op.frac, 2'b00};

        // ties keep a as the reference operand
        a_ge_b   = (a_op.exp >= b_op.exp);
        exp_diff = a_ge_b ? (a_op.exp - b_op.exp) : (b_op.exp - a_op.exp);

        // smaller operand slides right and bits past the guard bits drop off
        // a difference of 13 or more clears it completely
        if (a_ge_b) begin
            aligned.sign_shifted     = b_op.sign;
            aligned.frac_shifted     = sig_b >> exp_diff;
            aligned.sign_not_shifted = a_op.sign;
            aligned.frac_not_shifted = sig_a;
            aligned.exp_max          = a_op.exp;
        end else begin
            aligned.sign_shifted     = a_op.sign;
            aligned.frac_shifted     = sig_a >> exp_diff;
            aligned.sign_not_shifted = b_op.sign;
            aligned.frac_not_shifted = sig_b;
            aligned.exp_max          = b_op.exp;
        end
    end

    // the reference operand carries a hidden one unless both inputs were zero
    // sampled on every change of the stage output
    assert property (@(aligned)
        !$isunknown(aligned) |->
            (aligned.frac_not_shifted[fp16_add_pkg::MAN_W-1] ==
             ((req.a.exp != '0) || (req.b.exp != '0))))
    else $error("align: hidden bit does not match the input exponents");

endmodule

//--- add_sum.sv
// fp16 add magnitude sum stage
`timescale 1ns/1ns

module add_sum (
    input  fp16_add_pkg::aligned_t aligned,
    output fp16_add_pkg::sum_t     sum
);

    // operands zero extended by one bit for the carry
    logic [fp16_add_pkg::MAN_W:0] big_mag;
    logic [fp16_add_pkg::MAN_W:0] small_mag;

    // sign of the larger magnitude
    logic big_sign;

    // true when both operands point the same way
    logic same_sign;

    always_comb begin
        same_sign = (aligned.sign_shifted == aligned.sign_not_shifted);

        // order by magnitude so a subtract never goes negative
        // the shifted one is usually smaller, but equal exponents can flip that
        if (aligned.frac_not_shifted >= aligned.frac_shifted) begin
            big_mag   = {1'b0, aligned.frac_not_shifted};
            small_mag = {1'b0, aligned.frac_shifted};
            big_sign  = aligned.sign_not_shifted;
        end else begin
            big_mag   = {1'b0, aligned.frac_shifted};
            small_mag = {1'b0, aligned.frac_not_shifted};
            big_sign  = aligned.sign_shifted;
        end

        // exponent is adjusted later in normalize
        sum.exp = aligned.exp_max;

        if (same_sign) begin
            // true add, may carry into bit 13
            sum.mag  = big_mag + small_mag;
            sum.sign = aligned.sign_not_shifted;
        end else if (big_mag == small_mag) begin
            // exact cancellation gives +0
            sum.mag  = '0;
            sum.sign = 1'b0;
        end else begin
            sum.mag  = big_mag - small_mag;
            sum.sign = big_sign;
        end
    end

endmodule

//--- add_normalize.sv
// fp16 add normalize and pack stage
`timescale 1ns/1ns

module add_normalize (
    input  fp16_add_pkg::sum_t  sum,
    output fp16_add_pkg::fp16_t result
);

    // left shift needed to bring the leading one up to bit 12
    logic [3:0] lead_shift;

    // magnitude with the leading one at bit 12
    logic [fp16_add_pkg::MAN_W:0] norm_mag;

    // exponent with two spare bits so over and underflow stay visible
    // range is -12 up to 31 + 1
    logic signed [fp16_add_pkg::EXP_W+1:0] exp_wide;

    // leading one detect over bits 12..0
    // higher bits are visited last so they win
    always_comb begin
        lead_shift = '0;
        for (int i = 0; i < fp16_add_pkg::MAN_W; i++) begin
            if (sum.mag[i]) begin
                lead_shift = 4'(fp16_add_pkg::MAN_W - 1 - i);
            end
        end
    end

    always_comb begin
        if (sum.mag[fp16_add_pkg::MAN_W]) begin
            // carry out of the add, one step right
            norm_mag = sum.mag >> 1;
            exp_wide = $signed({2'b00, sum.exp}) + 7'sd1;
        end else begin
            // after cancellation the leading one may sit well below bit 12
            norm_mag = sum.mag << lead_shift;
            exp_wide = $signed({2'b00, sum.exp}) - $signed({3'b000, lead_shift});
        end
    end

    always_comb begin
        result.sign = sum.sign;
        result.exp  = exp_wide[fp16_add_pkg::EXP_W-1:0];
        // truncate, guard bits are dropped
        result.frac = norm_mag[fp16_add_pkg::MAN_W-2:2];

        if (sum.mag == '0) begin
            // nothing left, always +0
            result = '0;
        end else if (exp_wide >= fp16_add_pkg::EXP_INF) begin
            // overflow saturates to signed infinity
            result.exp  = fp16_add_pkg::EXP_W'(fp16_add_pkg::EXP_INF);
            result.frac = '0;
        end else if (exp_wide <= 0) begin
            // underflow flushes to signed zero, no subnormal output
            result.exp  = '0;
            result.frac = '0;
        end
    end

endmodule

//--- fp16_add_pipe.sv
// fp16 three stage adder top
`timescale 1ns/1ns

module fp16_add_pipe (
    input  logic                   clk,
    input  logic                   rst,
    input  logic                   in_valid,
    input  fp16_add_pkg::add_req_t req,
    output logic                   out_valid,
    output fp16_add_pkg::fp16_t    result
);

    // combinational stage outputs
    fp16_add_pkg::aligned_t align_c;
    fp16_add_pkg::sum_t     sum_c;
    fp16_add_pkg::fp16_t    norm_c;

    // stage registers 1 and 2, stage 3 is result itself
    fp16_add_pkg::aligned_t align_q;
    fp16_add_pkg::sum_t     sum_q;

    // valid bits beside the data
    logic align_valid;
    logic sum_valid;

    add_align u_align (
        .req     (req),
        .aligned (align_c)
    );

    add_sum u_sum (
        .aligned (align_q),
        .sum     (sum_c)
    );

    add_normalize u_normalize (
        .sum    (sum_q),
        .result (norm_c)
    );

    // valid pipeline, one stage per cycle and no stall
    always_ff @(posedge clk) begin
        if (rst) begin
            align_valid <= 1'b0;
            sum_valid   <= 1'b0;
            out_valid   <= 1'b0;
        end else begin
            align_valid <= in_valid;
            sum_valid   <= align_valid;
            out_valid   <= sum_valid;
        end
    end

    // data registers only load on a valid slot, result holds otherwise
    always_ff @(posedge clk) begin
        if (rst) begin
            align_q <= '0;
            sum_q   <= '0;
            result  <= '0;
        end else begin
            if (in_valid) begin
                align_q <= align_c;
            end
            if (align_valid) begin
                sum_q <= sum_c;
            end
            if (sum_valid) begin
                result <= norm_c;
            end
        end
    end

    // three cycle latency from accept to output, once reset is well behind
    assert property (@(posedge clk) disable iff (rst)
        (!$past(rst, 1) && !$past(rst, 2) && !$past(rst, 3)) |->
            (out_valid == $past(in_valid, 3)))
    else $error("pipe: out_valid is not in_valid delayed by three");

    // a carry above the hidden bit only comes from a same sign add
    assert property (@(posedge clk) disable iff (rst)
        (align_valid && sum_c.mag[fp16_add_pkg::MAN_W]) |->
            (align_q.sign_shifted == align_q.sign_not_shifted))
    else $error("sum: carry out on an effective subtract");

    // exponent 31 only ever encodes infinity here
    assert property (@(posedge clk) disable iff (rst)
        (sum_valid && norm_c.exp == fp16_add_pkg::EXP_W'(fp16_add_pkg::EXP_INF)) |->
            (norm_c.frac == '0))
    else $error("normalize: exponent 31 with nonzero fraction");

endmodule

//--- tb_fp16_add_pipe.sv
// fp16 adder pipeline testbench
`timescale 1ns/1ns

module tb_fp16_add_pipe;

    localparam int CLK_PERIOD   = 8;
    localparam int RESET_CYCLES = 10;

    // operation counts per test
    localparam int N_RAND_ADD = 400;
    localparam int N_RAND_MIX = 400;
    localparam int N_CANCEL   = 60;
    localparam int N_ZERO     = 40;
    localparam int N_LIMIT    = 60;
    localparam int N_GAPPED   = 200;
    localparam int MAX_GAP    = 3;

    // every op takes one cycle and gaps and reset add idle cycles on top
    localparam int TOTAL_OPS = N_RAND_ADD + N_RAND_MIX + N_CANCEL + N_ZERO
                               + N_LIMIT + N_GAPPED;
    localparam int WATCHDOG_CYCLES = TOTAL_OPS + N_GAPPED * MAX_GAP + RESET_CYCLES + 50;

    logic                   clk;
    logic                   rst;
    logic                   in_valid;
    fp16_add_pkg::add_req_t req;
    logic                   out_valid;
    fp16_add_pkg::fp16_t    result;

    // galois lfsr state for x^16 + x^14 + x^13 + x^11 + 1
    logic [15:0] lfsr_state = 16'd22;

    // expected results in issue order with their arrival cycle
    fp16_add_pkg::fp16_t exp_q[$];
    int                  due_q[$];
    string               name_q[$];

    // negedge counter shared by driver and monitor
    int    cyc = 0;
    int    errors = 0;
    string cur_test = "reset";
    logic  exp_valid;

    fp16_add_pipe uut (
        .clk       (clk),
        .rst       (rst),
        .in_valid  (in_valid),
        .req       (req),
        .out_valid (out_valid),
        .result    (result)
    );

    initial clk = 1'b0;
    always #(CLK_PERIOD / 2) clk = ~clk;

    function automatic logic [15:0] lfsr_step(input logic [15:0] s);
        logic [15:0] n;
        n = s >> 1;
        if (s[0]) begin
            n = n ^ 16'hB400;
        end
        return n;
    endfunction

    // one lfsr step per bit, msb taken first
    function automatic logic [31:0] rand_bits(input int n);
        logic [31:0] v;
        v = '0;
        for (int i = 0; i < n; i++) begin
            v = {v[30:0], lfsr_state[0]};
            lfsr_state = lfsr_step(lfsr_state);
        end
        return v;
    endfunction

    // normal exponent, never 0 and never 31
    function automatic logic [4:0] rand_exp();
        logic [4:0] e;
        e = 5'(rand_bits(5));
        while (e == 5'd0 || e == 5'd31) begin
            e = 5'(rand_bits(5));
        end
        return e;
    endfunction

    function automatic fp16_add_pkg::fp16_t rand_normal();
        fp16_add_pkg::fp16_t x;
        x.sign = (rand_bits(1) != 0);
        x.exp  = rand_exp();
        x.frac = 10'(rand_bits(10));
        return x;
    endfunction

    // reference model of align, sum and normalize on plain integers
    function automatic fp16_add_pkg::fp16_t model_add(input fp16_add_pkg::add_req_t r);
        int                  ea;
        int                  eb;
        int                  ma;
        int                  mb;
        int                  mag;
        int                  e;
        logic                sa;
        logic                sb;
        logic                s;
        fp16_add_pkg::fp16_t res;
        ea = int'(r.a.exp);
        eb = int'(r.b.exp);
        sa = r.a.sign;
        sb = (r.op == fp16_add_pkg::OP_SUB) ? ~r.b.sign : r.b.sign;
        // hidden one at bit 12 above two guard bits
        // zero exponent flushes
        ma = (ea == 0) ? 0 : (4096 + int'(r.a.frac) * 4);
        mb = (eb == 0) ? 0 : (4096 + int'(r.b.frac) * 4);
        // ties shift b
        if (ea >= eb) begin
            mb = mb >> (ea - eb);
            e  = ea;
        end else begin
            ma = ma >> (eb - ea);
            e  = eb;
        end
        if (sa == sb) begin
            mag = ma + mb;
            s   = sa;
        end else if (ma == mb) begin
            mag = 0;
            s   = 1'b0;
        end else if (ma > mb) begin
            mag = ma - mb;
            s   = sa;
        end else begin
            mag = mb - ma;
            s   = sb;
        end
        res = '0;
        if (mag == 0) begin
            return res;
        end
        if (mag >= 8192) begin
            mag = mag / 2;
            e   = e + 1;
        end else begin
            while (mag < 4096) begin
                mag = mag * 2;
                e   = e - 1;
            end
        end
        res.sign = s;
        if (e >= 31) begin
            res.exp = 5'd31;
        end else if (e > 0) begin
            res.exp  = 5'(e);
            res.frac = 10'((mag >> 2) & 1023);
        end
        return res;
    endfunction

    task automatic check_result(input string name, input fp16_add_pkg::fp16_t expected,
                                input fp16_add_pkg::fp16_t actual);
        if (actual !== expected) begin
            errors++;
            $display("error %s: expected %h actual %h", name, expected, actual);
            $display("tests failed");
            $fatal(1, "result mismatch");
        end
    endtask

    task automatic check_valid(input string name, input logic expected, input logic actual);
        if (actual !== expected) begin
            errors++;
            $display("error %s: expected out_valid %b actual %b", name, expected, actual);
            $display("tests failed");
            $fatal(1, "out_valid mismatch");
        end
    endtask

    // issue one op on the next rising edge
    // the result shows up four negedges on
    task automatic send(input fp16_add_pkg::add_req_t r);
        @(posedge clk);
        in_valid <= 1'b1;
        req      <= r;
        exp_q.push_back(model_add(r));
        due_q.push_back(cyc + 4);
        name_q.push_back(cur_test);
    endtask

    task automatic idle_cycle();
        @(posedge clk);
        in_valid <= 1'b0;
    endtask

    task automatic run_random_add();
        fp16_add_pkg::add_req_t r;
        cur_test = "random_add";
        for (int i = 0; i < N_RAND_ADD; i++) begin
            r.a  = rand_normal();
            r.b  = rand_normal();
            r.op = fp16_add_pkg::OP_ADD;
            send(r);
        end
    endtask

    // exponent gap up to 17 so the smaller fraction sometimes vanishes
    task automatic run_random_mix();
        fp16_add_pkg::add_req_t r;
        int                     d;
        int                     eb;
        cur_test = "random_mix";
        for (int i = 0; i < N_RAND_MIX; i++) begin
            r.a = rand_normal();
            d   = int'(rand_bits(5)) % 18;
            if (rand_bits(1) != 0) begin
                eb = int'(r.a.exp) + d;
            end else begin
                eb = int'(r.a.exp) - d;
            end
            if (eb < 1) begin
                eb = 1;
            end
            if (eb > 30) begin
                eb = 30;
            end
            r.b.sign = (rand_bits(1) != 0);
            r.b.exp  = 5'(eb);
            r.b.frac = 10'(rand_bits(10));
            r.op     = (rand_bits(1) != 0) ? fp16_add_pkg::OP_SUB : fp16_add_pkg::OP_ADD;
            send(r);
        end
    endtask

    task automatic run_cancel();
        fp16_add_pkg::add_req_t r;
        cur_test = "cancellation";
        for (int i = 0; i < N_CANCEL; i++) begin
            r.a = rand_normal();
            r.b = r.a;
            if (i % 3 == 0) begin
                // x - x
                r.op = fp16_add_pkg::OP_SUB;
            end else if (i % 3 == 1) begin
                // opposite signs with low fraction bits that differ
                r.b.frac = r.a.frac ^ 10'(rand_bits(4) | 32'd1);
                r.b.sign = ~r.a.sign;
                r.op     = fp16_add_pkg::OP_ADD;
            end else begin
                // 1.0 * 2^e minus just under it needs a long left shift
                if (r.a.exp < 5'd2) begin
                    r.a.exp = 5'd2;
                end
                r.a.frac = 10'h000;
                r.b.exp  = r.a.exp - 5'd1;
                r.b.frac = 10'h3FF ^ 10'(rand_bits(3));
                r.op     = fp16_add_pkg::OP_SUB;
            end
            send(r);
        end
    endtask

    task automatic run_zero();
        fp16_add_pkg::add_req_t r;
        cur_test = "zero_operands";
        for (int i = 0; i < N_ZERO; i++) begin
            r.a  = rand_normal();
            r.b  = rand_normal();
            r.op = fp16_add_pkg::OP_ADD;
            // zero exponent with a junk fraction still counts as zero
            if (i % 4 == 0 || i % 4 == 2 || i % 4 == 3) begin
                r.a.exp = 5'd0;
            end
            if (i % 4 == 1 || i % 4 == 2) begin
                r.b.exp = 5'd0;
            end
            if (i % 4 == 3) begin
                r.op = fp16_add_pkg::OP_SUB;
            end
            send(r);
        end
    endtask

    task automatic run_limits();
        fp16_add_pkg::add_req_t r;
        cur_test = "range_limits";
        for (int i = 0; i < N_LIMIT; i++) begin
            r.a = rand_normal();
            r.b = rand_normal();
            r.b.sign = r.a.sign;
            if (i % 2 == 0) begin
                // carry out of exponent 30 overflows
                r.a.exp = 5'd30;
                r.b.exp = 5'd29 + 5'(rand_bits(1));
                r.op    = fp16_add_pkg::OP_ADD;
            end else begin
                // tiny difference needs an exponent below 1
                r.a.exp = 5'd1;
                r.b.exp = 5'd1;
                r.op    = fp16_add_pkg::OP_SUB;
            end
            send(r);
        end
    endtask

    task automatic run_gapped();
        fp16_add_pkg::add_req_t r;
        int                     gap;
        cur_test = "valid_timing";
        for (int i = 0; i < N_GAPPED; i++) begin
            gap = int'(rand_bits(2));
            for (int g = 0; g < gap; g++) begin
                idle_cycle();
            end
            r.a  = rand_normal();
            r.b  = rand_normal();
            r.op = (rand_bits(1) != 0) ? fp16_add_pkg::OP_SUB : fp16_add_pkg::OP_ADD;
            send(r);
        end
    endtask

    // sample at the falling edge where outputs are settled
    always @(negedge clk) begin
        cyc = cyc + 1;
        exp_valid = (due_q.size() != 0) && (due_q[0] == cyc);
        check_valid(cur_test, exp_valid, out_valid);
        if (exp_valid) begin
            check_result(name_q[0], exp_q[0], result);
            void'(exp_q.pop_front());
            void'(due_q.pop_front());
            void'(name_q.pop_front());
        end
    end

    initial begin
        #(WATCHDOG_CYCLES * CLK_PERIOD);
        $display("watchdog expired, the simulation hung with %0d results pending",
                 due_q.size());
        $display("tests failed");
        $fatal(1, "timeout");
    end

    initial begin
        rst      = 1'b1;
        in_valid = 1'b0;
        req      = '0;
        repeat (RESET_CYCLES) @(posedge clk);
        rst <= 1'b0;
        run_random_add();
        run_random_mix();
        run_cancel();
        run_zero();
        run_limits();
        run_gapped();
        idle_cycle();
        // drain and then make sure out_valid stays low
        while (due_q.size() != 0) begin
            @(posedge clk);
        end
        repeat (5) @(posedge clk);
        if (errors == 0) begin
            $display("all tests passed");
            $finish;
        end else begin
            $display("tests failed");
            $fatal(1, "checks failed");
        end
    end

endmodule

//--- fp16_add.f
fp16_add_pkg.sv
add_align.sv
add_sum.sv
add_normalize.sv
fp16_add_pipe.sv
tb_fp16_add_pipe.sv

//--- Makefile
# Verilator build and run for the fp16 adder pipeline

VERILATOR ?= verilator
TOP       ?= tb_fp16_add_pipe
FILELIST  ?= fp16_add.f
OBJ_DIR   ?= obj_dir
VFLAGS    ?= --binary --timing --assert -j 0
PASS_MSG  ?= all tests passed

SRCS := $(filter %.sv %.v,$(shell cat $(FILELIST)))
BIN  := $(OBJ_DIR)/V$(TOP)

.PHONY: all build run clean

all: run

build: $(BIN)

# rebuilt only when a source or the file list changes
$(BIN): $(SRCS) $(FILELIST)
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) --Mdir $(OBJ_DIR) \
		-o V$(TOP) -f $(FILELIST)

# pass only if the pass message shows up in the output
run: $(BIN)
	@out="$$(./$(BIN))"; \
	echo "$$out"; \
	echo "$$out" | grep -q "$(PASS_MSG)"

clean:
	rm -rf $(OBJ_DIR)
